// File: rtl/power_up_timer.sv
`timescale 1ns/10ps

module power_up_timer
    import sensor_cfg_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start_config,
    output logic start_pulse
);

    logic [TIMER_W-1:0] cnt;    // Cycles since reset or restart

    // Counts up to the delay and parks there until the next restart
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (start_config) begin
            cnt <= '0;
        end else if (cnt < TIMER_W'(POWER_UP_CYCLES)) begin
            cnt <= cnt + 1'b1;
        end
    end

    // Single cycle, the counter passes this value only once
    assign start_pulse = (cnt == TIMER_W'(POWER_UP_CYCLES - 1)) && !start_config;

endmodule

// File: rtl/sccb_init_sequencer.sv
`timescale 1ns/10ps

module sccb_init_sequencer
    import sensor_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_config,
    input  logic             start_pulse,
    input  logic             sccb_done,
    output logic [IDX_W-1:0] entry_idx,
    output logic             sccb_exec,
    output logic             read_phase,
    output logic             init_done
);

    logic in_flight;    // Execute sent, completion still pending
    logic done_seen;
    logic more_left;

    // A completion only counts for a command we actually issued
    assign done_seen = sccb_done && in_flight;
    assign more_left = (entry_idx < IDX_W'(REG_COUNT));

    // Execute strobe, one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sccb_exec <= 1'b0;
        end else if (start_config) begin
            sccb_exec <= 1'b0;
        end else begin
            sccb_exec <= start_pulse || (done_seen && more_left);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (start_config) begin
            in_flight <= 1'b0;      // Drop whatever the master was doing
        end else if (sccb_exec) begin
            in_flight <= 1'b1;
        end else if (sccb_done) begin
            in_flight <= 1'b0;
        end
    end

    // Index moves on right after each execute
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_idx <= '0;
        end else if (start_config) begin
            entry_idx <= '0;
        end else if (sccb_exec) begin
            entry_idx <= entry_idx + 1'b1;
        end
    end

    // Leading entries are chip ID reads
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_phase <= 1'b1;
        end else if (start_config) begin
            read_phase <= 1'b1;
        end else if (entry_idx == IDX_W'(NUM_READ_REGS)) begin
            read_phase <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_done <= 1'b0;
        end else if (start_config) begin
            init_done <= 1'b0;
        end else if (done_seen && entry_idx == IDX_W'(REG_COUNT)) begin
            init_done <= 1'b1;     // Last write acknowledged
        end
    end

endmodule

// File: rtl/sensor_cfg_pkg.sv
package sensor_cfg_pkg;

    // Sensor register bus widths
    localparam int REG_ADDR_W = 16;
    localparam int REG_DATA_W = 8;

    // Register table size
    localparam int REG_COUNT     = 106;
    localparam int NUM_READ_REGS = 2;   // Chip ID high and low, read back first
    localparam int IDX_W         = 8;   // Wide enough for REG_COUNT itself

    // Power-up delay before the first bus access
    localparam int POWER_UP_CYCLES = 20000;
    localparam int TIMER_W         = 15;

    // One table entry, address in the upper bits
    typedef struct packed {
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] data;
    } reg_entry_t;

    // Command handed to the SCCB master
    typedef struct packed {
        reg_entry_t entry;
        logic       rd;     // 1 = read, 0 = write
    } sccb_cmd_t;

    // Returned past the end of the table.
    // Chip ID high is read-only, so a stray access changes nothing
    localparam reg_entry_t DEFAULT_ENTRY = '{addr: 16'h300a, data: 8'h00};

endpackage

// File: rtl/sensor_config_ctrl.sv
`timescale 1ns/10ps

module sensor_config_ctrl
    import sensor_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_config,  // Restart strobe
    input  logic      sccb_done,     // Completion from the SCCB master
    output logic      sccb_exec,
    output sccb_cmd_t cmd,
    output logic      init_done
);

    logic             start_pulse;
    logic [IDX_W-1:0] entry_idx;
    logic             read_phase;
    reg_entry_t       entry;

    power_up_timer u_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_config (start_config),
        .start_pulse  (start_pulse)
    );

    sccb_init_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_config (start_config),
        .start_pulse  (start_pulse),
        .sccb_done    (sccb_done),
        .entry_idx    (entry_idx),
        .sccb_exec    (sccb_exec),
        .read_phase   (read_phase),
        .init_done    (init_done)
    );

    sensor_reg_table u_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .entry_idx (entry_idx),
        .entry     (entry)
    );

    // Table entry plus direction toward the master
    assign cmd = '{entry: entry, rd: read_phase};

endmodule

// File: rtl/sensor_reg_table.sv
`timescale 1ns/10ps

module sensor_reg_table
    import sensor_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [IDX_W-1:0] entry_idx,
    output reg_entry_t       entry
);

    // Registered lookup, follows entry_idx one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry <= '0;
        end else begin
            case (entry_idx)
                // Chip ID, read back
                8'd0  : entry <= '{16'h300a, 8'h00};    // ID high
                8'd1  : entry <= '{16'h300b, 8'h00};    // ID low
                // Soft reset, then wake
                8'd2  : entry <= '{16'h3008, 8'h82};    // Reset and power down
                8'd3  : entry <= '{16'h3008, 8'h02};    // Normal operation
                8'd4  : entry <= '{16'h3103, 8'h02};    // Clock from PLL
                // Pad direction
                8'd5  : entry <= '{16'h3017, 8'hff};    // FREX, VSYNC, HREF, PCLK, D[9:6]
                8'd6  : entry <= '{16'h3018, 8'hff};    // D[5:0], GPIO
                // PLL and root divider
                8'd7  : entry <= '{16'h3037, 8'h13};
                8'd8  : entry <= '{16'h3108, 8'h01};
                // Analog and sensor core setup
                8'd9  : entry <= '{16'h3630, 8'h36};
                8'd10 : entry <= '{16'h3631, 8'h0e};
                8'd11 : entry <= '{16'h3632, 8'he2};
                8'd12 : entry <= '{16'h3633, 8'h12};
                8'd13 : entry <= '{16'h3621, 8'he0};
                8'd14 : entry <= '{16'h3704, 8'ha0};
                8'd15 : entry <= '{16'h3703, 8'h5a};
                8'd16 : entry <= '{16'h3715, 8'h78};
                8'd17 : entry <= '{16'h3717, 8'h01};
                8'd18 : entry <= '{16'h370b, 8'h60};
                8'd19 : entry <= '{16'h3705, 8'h1a};
                8'd20 : entry <= '{16'h3905, 8'h02};
                8'd21 : entry <= '{16'h3906, 8'h10};
                8'd22 : entry <= '{16'h3901, 8'h0a};
                8'd23 : entry <= '{16'h3731, 8'h12};
                8'd24 : entry <= '{16'h3600, 8'h08};    // VCM for autofocus
                8'd25 : entry <= '{16'h3601, 8'h33};
                // System control
                8'd26 : entry <= '{16'h302d, 8'h60};
                8'd27 : entry <= '{16'h3620, 8'h52};
                8'd28 : entry <= '{16'h371b, 8'h20};
                8'd29 : entry <= '{16'h471c, 8'h50};
                // Exposure control, gain ceiling
                8'd30 : entry <= '{16'h3a13, 8'h43};
                8'd31 : entry <= '{16'h3a18, 8'h00};
                8'd32 : entry <= '{16'h3a19, 8'hf8};
                8'd33 : entry <= '{16'h3635, 8'h13};
                8'd34 : entry <= '{16'h3636, 8'h03};
                8'd35 : entry <= '{16'h3634, 8'h40};
                8'd36 : entry <= '{16'h3622, 8'h01};
                // Light meter
                8'd37 : entry <= '{16'h3c01, 8'h34};
                8'd38 : entry <= '{16'h3c04, 8'h28};
                8'd39 : entry <= '{16'h3c05, 8'h98};
                8'd40 : entry <= '{16'h3c06, 8'h00};    // Threshold 1
                8'd41 : entry <= '{16'h3c07, 8'h08};
                8'd42 : entry <= '{16'h3c08, 8'h00};    // Threshold 2
                8'd43 : entry <= '{16'h3c09, 8'h1c};
                8'd44 : entry <= '{16'h3c0a, 8'h9c};    // Sample count
                8'd45 : entry <= '{16'h3c0b, 8'h40};
                // Window offsets
                8'd46 : entry <= '{16'h3810, 8'h00};    // H offset
                8'd47 : entry <= '{16'h3811, 8'h10};
                8'd48 : entry <= '{16'h3812, 8'h00};    // V offset
                8'd49 : entry <= '{16'h3708, 8'h64};
                // Black level
                8'd50 : entry <= '{16'h4001, 8'h02};    // Start line
                8'd51 : entry <= '{16'h4005, 8'h1a};    // Always update
                // Block reset and clock enables
                8'd52 : entry <= '{16'h3000, 8'h00};
                8'd53 : entry <= '{16'h3004, 8'hff};
                // Output format
                8'd54 : entry <= '{16'h4300, 8'h61};    // RGB565
                8'd55 : entry <= '{16'h501f, 8'h01};    // ISP RGB
                8'd56 : entry <= '{16'h440e, 8'h00};
                8'd57 : entry <= '{16'h5000, 8'ha7};    // ISP control
                // Exposure stable and fast zones
                8'd58 : entry <= '{16'h3a0f, 8'h30};
                8'd59 : entry <= '{16'h3a10, 8'h28};
                8'd60 : entry <= '{16'h3a1b, 8'h30};
                8'd61 : entry <= '{16'h3a1e, 8'h26};
                8'd62 : entry <= '{16'h3a11, 8'h60};
                8'd63 : entry <= '{16'h3a1f, 8'h14};
                8'd64 : entry <= '{16'h501d, 8'h40};    // ISP misc
                // Clock dividers, 24 MHz in
                8'd65 : entry <= '{16'h3035, 8'h21};    // System divider
                8'd66 : entry <= '{16'h3036, 8'h60};    // PLL multiplier
                8'd67 : entry <= '{16'h3c07, 8'h07};
                // Sensor window
                8'd68 : entry <= '{16'h3820, 8'h41};
                8'd69 : entry <= '{16'h3821, 8'h07};
                8'd70 : entry <= '{16'h3814, 8'h31};
                8'd71 : entry <= '{16'h3815, 8'h31};
                8'd72 : entry <= '{16'h3800, 8'h00};
                8'd73 : entry <= '{16'h3801, 8'h00};
                8'd74 : entry <= '{16'h3802, 8'h00};
                8'd75 : entry <= '{16'h3803, 8'hfa};
                8'd76 : entry <= '{16'h3804, 8'h0a};
                8'd77 : entry <= '{16'h3805, 8'h3f};
                8'd78 : entry <= '{16'h3806, 8'h06};
                8'd79 : entry <= '{16'h3807, 8'ha9};
                // Output size and frame totals
                8'd80 : entry <= '{16'h3808, 8'h03};    // Width 800
                8'd81 : entry <= '{16'h3809, 8'h20};
                8'd82 : entry <= '{16'h380a, 8'h01};    // Height 480
                8'd83 : entry <= '{16'h380b, 8'he0};
                8'd84 : entry <= '{16'h380c, 8'h07};    // H total
                8'd85 : entry <= '{16'h380d, 8'h64};
                8'd86 : entry <= '{16'h380e, 8'h02};    // V total
                8'd87 : entry <= '{16'h380f, 8'he4};
                8'd88 : entry <= '{16'h3813, 8'h04};
                8'd89 : entry <= '{16'h3618, 8'h00};
                8'd90 : entry <= '{16'h3612, 8'h29};
                8'd91 : entry <= '{16'h3709, 8'h52};
                8'd92 : entry <= '{16'h370c, 8'h03};
                // Exposure limits
                8'd93 : entry <= '{16'h3a02, 8'h11};    // 60 Hz max
                8'd94 : entry <= '{16'h3a03, 8'h58};
                8'd95 : entry <= '{16'h3a14, 8'h11};    // 50 Hz max
                8'd96 : entry <= '{16'h3a15, 8'h58};
                8'd97 : entry <= '{16'h4004, 8'h02};    // BLC over 2 lines
                8'd98 : entry <= '{16'h4713, 8'h03};
                8'd99 : entry <= '{16'h4407, 8'h04};
                8'd100: entry <= '{16'h460c, 8'h20};
                // DVP clock
                8'd101: entry <= '{16'h4837, 8'h16};
                8'd102: entry <= '{16'h3824, 8'h04};
                8'd103: entry <= '{16'h5001, 8'ha3};
                8'd104: entry <= '{16'h3b07, 8'h0a};    // Frame exposure mode
                8'd105: entry <= '{16'h503d, 8'h00};    // Color bar off
                default: entry <= DEFAULT_ENTRY;
            endcase
        end
    end

endmodule

// File: sensor_config_ctrl.f
rtl/sensor_cfg_pkg.sv
rtl/power_up_timer.sv
rtl/sccb_init_sequencer.sv
rtl/sensor_reg_table.sv
rtl/sensor_config_ctrl.sv
verification/sensor_config_ctrl_asserts.sv
verification/tb_sensor_config_ctrl.sv

// File: verification/init_cases.txt
# case  <name> <fixed|random> <done delay in cycles> <restart entry, -1 for none>
# check <entry> <address hex> <value hex> <read flag>
case fixed_min fixed 2 -1
case fixed_slow fixed 7 -1
case random_delay random 0 -1
case restart_mid fixed 3 40
case restart_early random 0 1
case restart_after_done fixed 2 106
check 0 300a 00 1
check 1 300b 00 1
check 2 3008 82 0
check 3 3008 02 0
check 4 3103 02 0
check 5 3017 ff 0
check 6 3018 ff 0
check 7 3037 13 0
check 8 3108 01 0
check 9 3630 36 0
check 10 3631 0e 0
check 11 3632 e2 0
check 13 3621 e0 0
check 16 3715 78 0
check 20 3905 02 0
check 24 3600 08 0
check 25 3601 33 0
check 26 302d 60 0
check 29 471c 50 0
check 30 3a13 43 0
check 32 3a19 f8 0
check 36 3622 01 0
check 37 3c01 34 0
check 40 3c06 00 0
check 44 3c0a 9c 0
check 45 3c0b 40 0
check 46 3810 00 0
check 47 3811 10 0
check 49 3708 64 0
check 50 4001 02 0
check 51 4005 1a 0
check 52 3000 00 0
check 53 3004 ff 0
check 54 4300 61 0
check 55 501f 01 0
check 57 5000 a7 0
check 58 3a0f 30 0
check 61 3a1e 26 0
check 64 501d 40 0
check 65 3035 21 0
check 66 3036 60 0
check 67 3c07 07 0
check 68 3820 41 0
check 69 3821 07 0
check 72 3800 00 0
check 75 3803 fa 0
check 77 3805 3f 0
check 79 3807 a9 0
check 80 3808 03 0
check 81 3809 20 0
check 82 380a 01 0
check 83 380b e0 0
check 84 380c 07 0
check 85 380d 64 0
check 86 380e 02 0
check 87 380f e4 0
check 90 3612 29 0
check 93 3a02 11 0
check 94 3a03 58 0
check 95 3a14 11 0
check 97 4004 02 0
check 100 460c 20 0
check 101 4837 16 0
check 102 3824 04 0
check 103 5001 a3 0
check 104 3b07 0a 0
check 105 503d 00 0

// File: verification/sensor_config_ctrl_asserts.sv
`timescale 1ns/10ps

module sensor_config_ctrl_asserts
    import sensor_cfg_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      start_config,
    input logic      sccb_exec,
    input sccb_cmd_t cmd,
    input logic      init_done
);

    int failures = 0;   // Failed assertion count

    // Execute is a single-cycle strobe
    property exec_single_cycle;
        @(posedge clk) disable iff (!rst_n)
            sccb_exec |=> !sccb_exec;
    endproperty

    property no_exec_after_done;
        @(posedge clk) disable iff (!rst_n)
            !(sccb_exec && init_done);
    endproperty

    // Only a restart may clear the done level
    property done_held;
        @(posedge clk) disable iff (!rst_n)
            $fell(init_done) |-> $past(start_config);
    endproperty

    // Command settled before the strobe and held while the master latches it
    property cmd_settled;
        @(posedge clk) disable iff (!rst_n)
            sccb_exec |-> $stable(cmd);
    endproperty

    property cmd_held;
        @(posedge clk) disable iff (!rst_n)
            (sccb_exec && !start_config) |=> $stable(cmd);
    endproperty

    assert property (exec_single_cycle) else begin
        failures++;
        $error("sccb_exec high on two cycles in a row");
    end
    assert property (no_exec_after_done) else begin
        failures++;
        $error("sccb_exec while init_done is high");
    end
    assert property (done_held) else begin
        failures++;
        $error("init_done fell without start_config");
    end
    assert property (cmd_settled) else begin
        failures++;
        $error("cmd changed on the sccb_exec cycle");
    end
    assert property (cmd_held) else begin
        failures++;
        $error("cmd changed right after sccb_exec");
    end

endmodule

bind sensor_config_ctrl sensor_config_ctrl_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_config (start_config),
    .sccb_exec    (sccb_exec),
    .cmd          (cmd),
    .init_done    (init_done)
);

// File: verification/tb_sensor_config_ctrl.sv
`timescale 1ns/10ps

module tb_sensor_config_ctrl
    import sensor_cfg_pkg::*;
();

    logic      clk;
    logic      rst_n;
    logic      start_config;
    logic      sccb_done;
    logic      sccb_exec;
    sccb_cmd_t cmd;
    logic      init_done;

    // Cases from the data file
    string case_name[$];
    bit    case_random[$];
    int    case_delay[$];
    int    case_restart[$];     // Entry number for start_config, -1 for none

    // Expected table entries by entry number
    bit                    exp_valid [REG_COUNT];
    logic [REG_ADDR_W-1:0] exp_addr  [REG_COUNT];
    logic [REG_DATA_W-1:0] exp_data  [REG_COUNT];
    logic                  exp_rd    [REG_COUNT];

    string  cur_name = "setup";
    integer seed;
    int     mismatch_count = 0;
    int     other_count = 0;
    int     watchdog_cycles = 0;

    sensor_config_ctrl dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_config (start_config),
        .sccb_done    (sccb_done),
        .sccb_exec    (sccb_exec),
        .cmd          (cmd),
        .init_done    (init_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    task automatic show_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        mismatch_count++;
        $display("Mismatch in %s: %s expected %0d (0x%0h), actual %0d (0x%0h)",
                 cur_name, what, expected, expected, actual, actual);
    endtask

    task automatic flag_error(input string msg);
        other_count++;
        $display("Error in %s: %s", cur_name, msg);
    endtask

    // Next rising edge, inputs change 1 ns later and strobes drop
    task automatic step_cycle;
        @(posedge clk);
        #1;
        sccb_done    = 1'b0;
        start_config = 1'b0;
    endtask

    // Cycles until sccb_exec shows up, -1 when it never does
    task automatic wait_exec(input int limit, output int cycles);
        int count;
        count  = 0;
        cycles = -1;
        while (cycles < 0 && count < limit) begin
            step_cycle();
            count++;
            @(negedge clk);
            if (sccb_exec) begin
                cycles = count;
            end else if (init_done) begin
                flag_error("init_done high while entries remain");
            end
        end
        if (cycles < 0) begin
            flag_error($sformatf("no sccb_exec within %0d cycles", limit));
        end
    endtask

    // Bus master answers after the given number of cycles
    task automatic answer_done(input int delay);
        for (int i = 1; i <= delay; i++) begin
            step_cycle();
            if (i == delay) begin
                sccb_done = 1'b1;
            end
            @(negedge clk);
            if (sccb_exec) begin
                flag_error("sccb_exec while a command is in flight");
            end
        end
    endtask

    function automatic int pick_delay(input int c);
        int rnd;
        if (case_random[c]) begin
            rnd = $random(seed);
            return 2 + (rnd & 7);   // 2 to 9 cycles
        end
        return case_delay[c];
    endfunction

    task automatic check_command(input int n);
        logic exp_read;
        exp_read = (n < NUM_READ_REGS);     // Chip ID reads come first
        if (cmd.rd !== exp_read) begin
            show_mismatch($sformatf("read flag of entry %0d", n), exp_read, cmd.rd);
        end
        if (exp_valid[n]) begin
            if (cmd.entry.addr !== exp_addr[n]) begin
                show_mismatch($sformatf("address of entry %0d", n), exp_addr[n],
                              cmd.entry.addr);
            end
            if (cmd.entry.data !== exp_data[n]) begin
                show_mismatch($sformatf("value of entry %0d", n), exp_data[n],
                              cmd.entry.data);
            end
            if (cmd.rd !== exp_rd[n]) begin
                show_mismatch($sformatf("listed read flag of entry %0d", n), exp_rd[n],
                              cmd.rd);
            end
        end
    endtask

    task automatic pulse_restart;
        step_cycle();
        start_config = 1'b1;
        @(negedge clk);
        if (sccb_exec) begin
            flag_error("sccb_exec during restart");
        end
        step_cycle();
        @(negedge clk);
        if (init_done !== 1'b0) begin
            show_mismatch("init_done after restart", 0, init_done);
        end
        if (sccb_exec !== 1'b0) begin
            show_mismatch("sccb_exec after restart", 0, sccb_exec);
        end
    endtask

    task automatic apply_reset;
        step_cycle();
        rst_n = 1'b0;
        repeat (9) begin
            step_cycle();
        end
        @(negedge clk);
        if (sccb_exec !== 1'b0 || init_done !== 1'b0) begin
            flag_error("sccb_exec or init_done not low in reset");
        end
        step_cycle();
        rst_n = 1'b1;   // Held low over 10 edges
    endtask

    task automatic run_case(input int c);
        int n;
        int cycles;
        bit replay;
        bit restart_pending;
        cur_name        = case_name[c];
        restart_pending = (case_restart[c] >= 0);
        apply_reset();
        replay = 1'b1;
        while (replay) begin
            replay = 1'b0;
            wait_exec(POWER_UP_CYCLES + 10, cycles);
            if (cycles < 0) begin
                return;
            end
            if (cycles != POWER_UP_CYCLES) begin
                show_mismatch("cycles to first sccb_exec", POWER_UP_CYCLES, cycles);
            end
            n = 0;
            while (n < REG_COUNT && !replay) begin
                check_command(n);
                if (restart_pending && n == case_restart[c]) begin
                    restart_pending = 1'b0;
                    pulse_restart();    // Mid-sequence, no completion sent
                    replay = 1'b1;
                end else begin
                    answer_done(pick_delay(c));
                    if (n < REG_COUNT - 1) begin
                        wait_exec(10, cycles);
                        if (cycles < 0) begin
                            return;
                        end
                        if (cycles != 1) begin
                            show_mismatch("cycles from sccb_done to sccb_exec", 1, cycles);
                        end
                    end
                    n++;
                end
            end
            if (!replay) begin
                step_cycle();
                @(negedge clk);
                if (init_done !== 1'b1) begin
                    show_mismatch("init_done after last completion", 1, init_done);
                end
                if (sccb_exec !== 1'b0) begin
                    flag_error("sccb_exec after the last entry");
                end
                if (restart_pending) begin
                    restart_pending = 1'b0;
                    pulse_restart();
                    replay = 1'b1;
                end
            end
        end
        // Done level holds and the bus stays quiet
        repeat (20) begin
            step_cycle();
            @(negedge clk);
            if (init_done !== 1'b1) begin
                show_mismatch("init_done while idle", 1, init_done);
            end
            if (sccb_exec) begin
                flag_error("sccb_exec after configuration finished");
            end
        end
    endtask

    initial begin
        int          fd;
        int          cnt;
        int          dly;
        int          rst_at;
        int          idx;
        int          r;
        int          max_delay;
        int          runs;
        int          budget;
        logic [31:0] a;
        logic [31:0] v;
        string       line;
        string       kind;
        string       nm;
        string       mode;
        rst_n        = 1'b0;
        start_config = 1'b0;
        sccb_done    = 1'b0;
        seed         = 30;
        foreach (exp_valid[i]) begin
            exp_valid[i] = 1'b0;
        end
        fd = $fopen("verification/init_cases.txt", "r");
        if (fd == 0) begin
            flag_error("cannot open verification/init_cases.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                cnt = $sscanf(line, "%s", kind);
                if (cnt != 1 || kind.substr(0, 0) == "#") begin
                    continue;
                end
                if (kind == "case") begin
                    cnt = $sscanf(line, "%s %s %s %d %d", kind, nm, mode, dly, rst_at);
                    if (cnt != 5 || (mode != "random" && dly < 2)) begin
                        flag_error($sformatf("bad case line: %s", line));
                    end else begin
                        case_name.push_back(nm);
                        case_random.push_back(mode == "random");
                        case_delay.push_back(dly);
                        case_restart.push_back(rst_at);
                    end
                end else if (kind == "check") begin
                    cnt = $sscanf(line, "%s %d %h %h %d", kind, idx, a, v, r);
                    if (cnt != 5 || idx < 0 || idx >= REG_COUNT) begin
                        flag_error($sformatf("bad check line: %s", line));
                    end else begin
                        exp_valid[idx] = 1'b1;
                        exp_addr[idx]  = a[REG_ADDR_W-1:0];
                        exp_data[idx]  = v[REG_DATA_W-1:0];
                        exp_rd[idx]    = (r != 0);
                    end
                end else begin
                    flag_error($sformatf("unknown line kind %s", kind));
                end
            end
            $fclose(fd);
        end
        if (case_name.size() == 0) begin
            flag_error("no cases to run");
        end else begin
            budget = 1000;
            foreach (case_name[i]) begin
                max_delay = case_random[i] ? 9 : case_delay[i];
                runs      = (case_restart[i] >= 0) ? 2 : 1;
                budget += runs * (10 + POWER_UP_CYCLES + REG_COUNT * (max_delay + 10)) + 20;
            end
            watchdog_cycles = budget;
            foreach (case_name[i]) begin
                run_case(i);
            end
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, other_count, dut.u_asserts.failures);
        if (mismatch_count == 0 && other_count == 0 && dut.u_asserts.failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog, armed once the cases are known
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: run still busy after %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
